// File: hw/rvdec_macros.svh
`ifndef RVDEC_MACROS_SVH
`define RVDEC_MACROS_SVH

// first fetch address out of reset
`define RVDEC_RESET_PC 32'h0000_0000

// instruction bus address width
`define RVDEC_ADR_W 32

// multiply/divide detect off unless asked for
`define RVDEC_MDU_DEFAULT 1'b0

`endif

// File: hw/rvdec_pkg.sv
`default_nettype none

package rvdec_pkg;

   // one instruction or address word
   typedef logic [31:0] word_t;

   // opcode bits 6:2, low two bits are always 11 for rv32i
   typedef logic [4:0] opcode_t;

   // funct3 field, instruction bits 14:12
   typedef logic [2:0] funct3_t;

   // instruction fetch bus cycle states
   // idle: no cycle, pc settles
   // bus: cyc/stb out, waiting for ack
   // hold: word captured, offered to decoders
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      BUS  = 2'd1,
      HOLD = 2'd2
   } fetch_state_t;

endpackage

`default_nettype wire

// File: hw/rvdec_instr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rvdec_instr_if;
   import rvdec_pkg::*;

   // handshake
   logic    valid;
   logic    ready;
   // fields for the control decoder
   opcode_t opcode;
   funct3_t funct3;
   logic    imm30;
   logic    imm25;
   logic    op20;
   logic    op21;
   logic    op22;
   logic    op26;
   // whole word, immediate decoder picks its bits
   word_t   word;

   // ready comes from the output stage at the top
   modport fetch (output valid, opcode, funct3, imm30, imm25, op20, op21, op22, op26,
                  output word, input ready);
   modport ctrl (input opcode, funct3, imm30, imm25, op20, op21, op22, op26);
   modport imm (input opcode, word);

endinterface

`default_nettype wire

// File: hw/rvdec_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvdec_macros.svh"

module rvdec_fetch (
   input  wire                     i_clk,
   input  wire                     i_rst_n,
   // redirect
   input  wire                     i_pc_load,
   input  wire  rvdec_pkg::word_t  i_pc_target,
   // wishbone classic master, read only
   output logic                    o_ibus_cyc,
   output logic                    o_ibus_stb,
   output rvdec_pkg::word_t        o_ibus_adr,
   input  wire  rvdec_pkg::word_t  i_ibus_dat,
   input  wire                     i_ibus_ack,
   // to the decoders
   rvdec_instr_if.fetch            instr
);
   import rvdec_pkg::*;

   fetch_state_t state_q;
   fetch_state_t state_d;
   word_t        pc_q;
   word_t        word_q;
   logic         xfer;

   // word taken by the decoders this cycle
   assign xfer = instr.valid & instr.ready;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            state_d = BUS;
         end
         BUS: begin
            if (i_ibus_ack) begin
               state_d = HOLD;
            end
         end
         HOLD: begin
            if (xfer) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
      // redirect aborts a cycle in flight and drops a held word
      if (i_pc_load) begin
         state_d = IDLE;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= IDLE;
         pc_q    <= `RVDEC_RESET_PC;
      end else begin
         state_q <= state_d;
         // redirect wins over the sequential step
         if (i_pc_load) begin
            pc_q <= i_pc_target;
         end else if (xfer) begin
            pc_q <= pc_q + 32'd4;
         end
      end
   end

   // word register, loaded on the ack beat
   always_ff @(posedge i_clk) begin
      if ((state_q == BUS) && i_ibus_ack) begin
         word_q <= i_ibus_dat;
      end
   end

   // cyc and stb rise and fall together
   assign o_ibus_cyc = (state_q == BUS);
   assign o_ibus_stb = (state_q == BUS);
   assign o_ibus_adr = pc_q;

   // held word never offered in the redirect cycle
   assign instr.valid  = (state_q == HOLD) & ~i_pc_load;
   assign instr.opcode = word_q[6:2];
   assign instr.funct3 = word_q[14:12];
   assign instr.imm30  = word_q[30];
   assign instr.imm25  = word_q[25];
   assign instr.op20   = word_q[20];
   assign instr.op21   = word_q[21];
   assign instr.op22   = word_q[22];
   assign instr.op26   = word_q[26];
   assign instr.word   = word_q;

   // stb stays up inside its cycle until ack or an abort
   a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_ibus_stb && !i_ibus_ack && !i_pc_load |=> o_ibus_stb && o_ibus_cyc);

   // address frozen while the slave stalls, unless the cycle is aborted
   a_adr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_ibus_stb && !i_ibus_ack |=> !o_ibus_stb || $stable(o_ibus_adr));

   // single beat per cycle, cyc drops right after ack
   a_cyc_end: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_ibus_stb && i_ibus_ack |=> !o_ibus_cyc);

endmodule

`default_nettype wire

// File: hw/rvdec_ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvdec_macros.svh"

module rvdec_ctrl_decode #(
   parameter bit MDU = `RVDEC_MDU_DEFAULT
) (
   input  wire          i_clk,
   input  wire          i_rst_n,
   rvdec_instr_if.ctrl  instr,
   // transfer strobe from the top
   input  wire          i_load,
   output logic         o_branch_op,
   output logic         o_cond_branch,
   output logic         o_slt_or_branch,
   output logic         o_op_b_source,
   output logic         o_rd_mem_en,
   output logic         o_mem_cmd,
   output logic         o_ctrl_utype,
   output logic         o_shift_op,
   output logic         o_sh_right,
   output logic         o_two_stage_op,
   output logic         o_rd_op,
   output logic         o_e_op,
   output logic         o_ebreak,
   output logic         o_ctrl_mret,
   output logic         o_mdu_op
);
   import rvdec_pkg::*;

   localparam opcode_t OPC_OP = 5'b01100;

   opcode_t op;
   funct3_t f3;
   logic    mdu_word;
   logic    sys_priv;

   // short names for the equations below
   assign op = instr.opcode;
   assign f3 = instr.funct3;

   // funct7 = 0000001 on an op word
   assign mdu_word = (op == OPC_OP) & instr.imm25 & ~instr.imm30;

   // ecall/ebreak/mret group, funct3 zero
   // bits 22 and 26 set means wfi or another privileged word, not ours
   assign sys_priv = op[4] & op[2] & ~(|f3) & ~instr.op22 & ~instr.op26;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_branch_op     <= 1'b0;
         o_cond_branch   <= 1'b0;
         o_slt_or_branch <= 1'b0;
         o_op_b_source   <= 1'b0;
         o_rd_mem_en     <= 1'b0;
         o_mem_cmd       <= 1'b0;
         o_ctrl_utype    <= 1'b0;
         o_shift_op      <= 1'b0;
         o_sh_right      <= 1'b0;
         o_two_stage_op  <= 1'b0;
         o_rd_op         <= 1'b0;
         o_e_op          <= 1'b0;
         o_ebreak        <= 1'b0;
         o_ctrl_mret     <= 1'b0;
         o_mdu_op        <= 1'b0;
      end else if (i_load) begin
         // jal, jalr, branches; system has op[2] set and stays out
         o_branch_op     <= op[4] & ~op[2];
         // branches only, jumps have op[0] set
         o_cond_branch   <= op[4] & ~op[2] & ~op[0];
         o_slt_or_branch <= op[4] | (f3[1] & op[2] & ~f3[2]);
         o_op_b_source   <= op[4] | (op[3] & ~op[0]);
         // loads
         o_rd_mem_en     <= ~op[4] & ~op[3] & ~op[2] & ~op[0];
         // stores
         o_mem_cmd       <= ~op[4] & op[3] & ~op[2];
         // lui and auipc
         o_ctrl_utype    <= ~op[4] & op[2] & op[0];
         // sll/srl/sra in op and op-imm, multiply words excluded
         o_shift_op      <= ~op[4] & op[2] & ~op[0] & f3[0] & ~f3[1] & ~(MDU & mdu_word);
         o_sh_right      <= (f3[2] & op[2]) | (op[4] & ~f3[1]) |
                            (~f3[0] & ~f3[2]) | (~f3[2] & ~op[2]);
         o_two_stage_op  <= ~op[2] | (f3[0] & ~f3[1] & ~op[0]) |
                            (f3[1] & ~f3[2] & ~op[0]);
         // everything except branches and stores writes rd
         o_rd_op         <= op[0] | op[2] | ~op[3];
         // ecall and ebreak, bit 21 tells mret apart
         o_e_op          <= sys_priv & ~instr.op21;
         o_ebreak        <= instr.op20;
         o_ctrl_mret     <= sys_priv & instr.op21;
         o_mdu_op        <= MDU & mdu_word;
      end
   end

endmodule

`default_nettype wire

// File: hw/rvdec_imm_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rvdec_imm_decode (
   input  wire          i_clk,
   input  wire          i_rst_n,
   rvdec_instr_if.imm   instr,
   input  wire          i_load,
   output rvdec_pkg::word_t o_imm,
   // output handshake
   output logic         o_dec_valid,
   input  wire          i_dec_ready
);
   import rvdec_pkg::*;

   localparam opcode_t OPC_LUI    = 5'b01101;
   localparam opcode_t OPC_AUIPC  = 5'b00101;
   localparam opcode_t OPC_JAL    = 5'b11011;
   localparam opcode_t OPC_BRANCH = 5'b11000;
   localparam opcode_t OPC_STORE  = 5'b01000;

   word_t w;
   word_t imm_d;

   assign w = instr.word;

   // format from opcode, sign always from bit 31
   always_comb begin
      case (instr.opcode)
         OPC_LUI, OPC_AUIPC: imm_d = {w[31:12], 12'b0};
         OPC_JAL:            imm_d = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         OPC_BRANCH:         imm_d = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         OPC_STORE:          imm_d = {{21{w[31]}}, w[30:25], w[11:7]};
         // i-type: jalr, loads, op-imm, system
         default:            imm_d = {{21{w[31]}}, w[30:20]};
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_load) begin
         o_imm <= imm_d;
      end
   end

   // set on load, cleared when drained with nothing new behind it
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_dec_valid <= 1'b0;
      end else if (i_load) begin
         o_dec_valid <= 1'b1;
      end else if (i_dec_ready) begin
         o_dec_valid <= 1'b0;
      end
   end

   // stalled output keeps its immediate, relies on the top gating i_load
   a_imm_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_dec_valid && !i_dec_ready |=> o_dec_valid && $stable(o_imm));

endmodule

`default_nettype wire

// File: hw/rvdec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvdec_macros.svh"

module rvdec_top #(
   parameter bit MDU = `RVDEC_MDU_DEFAULT
) (
   input  wire                     i_clk,
   input  wire                     i_rst_n,
   // instruction bus
   output logic                    o_ibus_cyc,
   output logic                    o_ibus_stb,
   output logic [`RVDEC_ADR_W-1:0] o_ibus_adr,
   input  wire  rvdec_pkg::word_t  i_ibus_dat,
   input  wire                     i_ibus_ack,
   // redirect
   input  wire                     i_pc_load,
   input  wire  rvdec_pkg::word_t  i_pc_target,
   // decoded instruction out
   output logic                    o_dec_valid,
   input  wire                     i_dec_ready,
   output logic                    o_branch_op,
   output logic                    o_cond_branch,
   output logic                    o_slt_or_branch,
   output logic                    o_op_b_source,
   output logic                    o_rd_mem_en,
   output logic                    o_mem_cmd,
   output logic                    o_ctrl_utype,
   output logic                    o_shift_op,
   output logic                    o_sh_right,
   output logic                    o_two_stage_op,
   output logic                    o_rd_op,
   output logic                    o_e_op,
   output logic                    o_ebreak,
   output logic                    o_ctrl_mret,
   output logic                    o_mdu_op,
   output rvdec_pkg::word_t        o_imm
);

   rvdec_instr_if u_instr ();

   logic dec_load;

   // output stage free when empty or draining this cycle
   assign u_instr.ready = ~o_dec_valid | i_dec_ready;
   // both decoders load on the same transfer
   assign dec_load      = u_instr.valid & u_instr.ready;

   rvdec_fetch u_fetch (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_pc_load   (i_pc_load),
      .i_pc_target (i_pc_target),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_ibus_stb  (o_ibus_stb),
      .o_ibus_adr  (o_ibus_adr),
      .i_ibus_dat  (i_ibus_dat),
      .i_ibus_ack  (i_ibus_ack),
      .instr       (u_instr.fetch)
   );

   rvdec_ctrl_decode #(.MDU(MDU)) u_ctrl (
      .i_clk (i_clk), .i_rst_n (i_rst_n), .instr (u_instr.ctrl), .i_load (dec_load),
      .o_branch_op (o_branch_op), .o_cond_branch (o_cond_branch),
      .o_slt_or_branch (o_slt_or_branch), .o_op_b_source (o_op_b_source),
      .o_rd_mem_en (o_rd_mem_en), .o_mem_cmd (o_mem_cmd), .o_ctrl_utype (o_ctrl_utype),
      .o_shift_op (o_shift_op), .o_sh_right (o_sh_right), .o_two_stage_op (o_two_stage_op),
      .o_rd_op (o_rd_op), .o_e_op (o_e_op), .o_ebreak (o_ebreak),
      .o_ctrl_mret (o_ctrl_mret), .o_mdu_op (o_mdu_op)
   );

   rvdec_imm_decode u_imm (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .instr       (u_instr.imm),
      .i_load      (dec_load),
      .o_imm       (o_imm),
      .o_dec_valid (o_dec_valid),
      .i_dec_ready (i_dec_ready)
   );

endmodule

`default_nettype wire

// File: bench/rvdec_imem.sv
`timescale 1ns/1ps
`default_nettype none

module rvdec_imem #(
   parameter integer SEED = 54
) (
   input  wire                    i_clk,
   input  wire                    i_rst_n,
   input  wire                    i_cyc,
   input  wire                    i_stb,
   input  wire  rvdec_pkg::word_t i_adr,
   output rvdec_pkg::word_t       o_dat,
   output logic                   o_ack
);
   import rvdec_pkg::*;

   // 64 words, loaded by the testbench
   word_t  mem [0:63];
   integer seed;
   integer wait_n;
   logic   busy;

   initial begin
      seed   = SEED;
      wait_n = 0;
      busy   = 1'b0;
      o_ack  = 1'b0;
      o_dat  = '0;
   end

   // slave outputs move on the falling edge
   always @(negedge i_clk) begin
      if (!i_rst_n) begin
         o_ack <= 1'b0;
         busy = 1'b0;
      end else if (o_ack) begin
         // single beat, master drops stb after ack
         o_ack <= 1'b0;
         busy = 1'b0;
      end else if (i_cyc && i_stb) begin
         // new request draws 0 to 3 wait states
         if (!busy) begin
            busy = 1'b1;
            wait_n = $random(seed) & 3;
         end
         if (wait_n == 0) begin
            o_ack <= 1'b1;
            o_dat <= mem[i_adr[7:2]];
         end else begin
            wait_n = wait_n - 1;
         end
      end else begin
         // cycle aborted by a redirect
         busy = 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: bench/rvdec_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvdec_macros.svh"

module rvdec_tb;
   import rvdec_pkg::*;

   // outputs to check, watchdog at 12 cycles per instruction over 64
   localparam integer N_OUT   = 48;
   localparam integer WDOG_NS = 64 * 12 * 8;

   logic        clk, rst_n, pc_load, dec_ready;
   logic        ibus_cyc, ibus_stb, ibus_ack, dec_valid;
   word_t       pc_target, ibus_adr, ibus_dat, dec_imm;
   // top 11 bits go to the model, all 15 to the hold check
   logic [14:0] flags, held_flags;

   integer      seed, i, n_out, n_steps, n_redir, phase;
   integer      bus_errs, out_errs, hold_errs;
   word_t       prog [0:63];
   word_t       exp_pc, exp_bus, pend_pc, last_adr, held_imm, new_tgt;
   logic        pend, last_stb, last_load, last_valid, last_ready, ready_n;

   rvdec_top #(.MDU(1'b1)) u_dut (
      .i_clk (clk), .i_rst_n (rst_n),
      .o_ibus_cyc (ibus_cyc), .o_ibus_stb (ibus_stb), .o_ibus_adr (ibus_adr),
      .i_ibus_dat (ibus_dat), .i_ibus_ack (ibus_ack),
      .i_pc_load (pc_load), .i_pc_target (pc_target),
      .o_dec_valid (dec_valid), .i_dec_ready (dec_ready),
      .o_branch_op (flags[14]), .o_cond_branch (flags[13]), .o_rd_mem_en (flags[12]),
      .o_mem_cmd (flags[11]), .o_ctrl_utype (flags[10]), .o_shift_op (flags[9]),
      .o_rd_op (flags[8]), .o_e_op (flags[7]), .o_ebreak (flags[6]),
      .o_ctrl_mret (flags[5]), .o_mdu_op (flags[4]), .o_slt_or_branch (flags[3]),
      .o_op_b_source (flags[2]), .o_sh_right (flags[1]), .o_two_stage_op (flags[0]),
      .o_imm (dec_imm)
   );

   rvdec_imem #(.SEED(54)) u_imem (
      .i_clk (clk), .i_rst_n (rst_n), .i_cyc (ibus_cyc), .i_stb (ibus_stb),
      .i_adr (ibus_adr), .o_dat (ibus_dat), .o_ack (ibus_ack)
   );

   always #4 clk = ~clk;

   // random rv32i word, classes picked by k
   task automatic gen_instr(output word_t w);
      word_t  r;
      integer k;
      r = $random(seed);
      k = $random(seed) & 15;
      case (k)
         0: w = {r[31:12], r[11:7], 7'b0110111};
         1: w = {r[31:12], r[11:7], 7'b0010111};
         2: w = {r[31:12], r[11:7], 7'b1101111};
         3: w = {r[31:15], 3'b000, r[11:7], 7'b1100111};
         // funct3 010 and 011 are not branches
         4: w = {r[31:15], r[14] | r[13], r[13:12], r[11:7], 7'b1100011};
         5: w = {r[31:15], r[14], r[13] & ~r[14], r[12] & ~r[13], r[11:7], 7'b0000011};
         6: w = {r[31:15], 1'b0, r[13], r[12] & ~r[13], r[11:7], 7'b0100011};
         7, 8: begin
            w = {r[31:12], r[11:7], 7'b0010011};
            // slli/srli/srai carry a shamt, bit 30 only on srai
            if (r[13:12] == 2'b01) begin
               w[31:25] = {1'b0, r[30] & r[14], 5'b0};
            end
         end
         9, 10: begin
            w = {7'b0, r[24:12], r[11:7], 7'b0110011};
            if (r[14:12] == 3'b000 || r[14:12] == 3'b101) begin
               w[30] = r[30];
            end
         end
         11, 12: w = {7'b0000001, r[24:12], r[11:7], 7'b0110011};
         13: w = 32'h0000_0073;
         14: w = 32'h0010_0073;
         default: w = 32'h3020_0073;
      endcase
   endtask

   // flag meanings per instruction class
   function automatic logic [10:0] model_flags(input word_t w);
      logic [6:0] opc;
      logic       is_br, is_st, is_op, is_mul;
      opc    = w[6:0];
      is_br  = (opc == 7'b1100011);
      is_st  = (opc == 7'b0100011);
      is_op  = (opc == 7'b0110011);
      is_mul = is_op && (w[31:25] == 7'b0000001);
      return {is_br || opc == 7'b1101111 || opc == 7'b1100111, is_br,
              opc == 7'b0000011, is_st, opc == 7'b0110111 || opc == 7'b0010111,
              (opc == 7'b0010011 || (is_op && !is_mul)) && w[13:12] == 2'b01,
              !(is_br || is_st), w == 32'h0000_0073 || w == 32'h0010_0073,
              w[20], w == 32'h3020_0073, is_mul};
   endfunction

   // immediate by format, sign from the top bit of each field
   function automatic word_t model_imm(input word_t w);
      logic [11:0] i12;
      logic [11:0] s12;
      logic [12:0] b13;
      logic [20:0] j21;
      i12 = w[31:20];
      s12 = {w[31:25], w[11:7]};
      b13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
      j21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
      case (w[6:0])
         7'b0110111, 7'b0010111: return {w[31:12], 12'h000};
         7'b1101111: return {{11{j21[20]}}, j21};
         7'b1100011: return {{19{b13[12]}}, b13};
         7'b0100011: return {{20{s12[11]}}, s12};
         default: return {{20{i12[11]}}, i12};
      endcase
   endfunction

   // one falling edge, outputs are settled since the rising edge
   task check_and_drive;
      word_t w;
      // bus side, ack read here is what the last rising edge saw
      if (ibus_stb != ibus_cyc) begin
         bus_errs++;
         $display("ERR %0t: cyc %b and stb %b differ", $time, ibus_cyc, ibus_stb);
      end
      if (n_steps == 0 && !ibus_stb) begin
         bus_errs++;
         $display("ERR %0t: no bus cycle one clock after reset", $time);
      end
      if (last_stb && ibus_ack) begin
         exp_bus = exp_bus + 32'd4;
         if (ibus_cyc) begin
            bus_errs++;
            $display("ERR %0t: cyc still high after ack", $time);
         end
      end else if (last_stb && !last_load && (!ibus_stb || ibus_adr != last_adr)) begin
         bus_errs++;
         $display("ERR %0t: stb or adr moved before ack, adr %h", $time, ibus_adr);
      end
      if (last_load) begin
         exp_bus = pc_target;
      end
      // new cycle starts, address from the model pc
      if (ibus_stb && !(last_stb && !ibus_ack) && ibus_adr != exp_bus) begin
         bus_errs++;
         $display("ERR %0t: bus adr %h, expected %h", $time, ibus_adr, exp_bus);
      end
      // stalled output keeps flags and immediate
      if (last_valid && !last_ready &&
          (!dec_valid || flags != held_flags || dec_imm != held_imm)) begin
         hold_errs++;
         $display("ERR %0t: output changed while stalled", $time);
      end
      held_flags = flags;
      held_imm   = dec_imm;
      if (phase == 0 && n_redir < 2 && n_out >= 12 + 18 * n_redir) begin
         phase = 1;
      end
      ready_n = (phase == 0) ? (($random(seed) & 3) != 0) : 1'b0;
      if (dec_valid && ready_n) begin
         w = prog[exp_pc[7:2]];
         if (flags[14:4] != model_flags(w) || dec_imm != model_imm(w)) begin
            out_errs++;
            $display("ERR %0t: pc %h word %h flags %b imm %h, expected %b %h", $time,
                     exp_pc, w, flags[14:4], dec_imm, model_flags(w), model_imm(w));
         end
         n_out++;
         exp_pc = pend ? pend_pc : exp_pc + 32'd4;
         pend   = 1'b0;
      end
      last_load = 1'b0;
      if (phase == 2) begin
         phase = 0;
      end else if (phase == 1 && dec_valid &&
                   ((n_redir == 0) ? (last_stb && ibus_ack) : ibus_stb)) begin
         // output parked, first redirect drops the word held behind it
         // second one lands on a bus cycle in flight
         new_tgt   = (n_redir == 0) ? 32'h0000_0080 : 32'h0000_0024;
         pc_target <= new_tgt;
         pend      = 1'b1;
         pend_pc   = new_tgt;
         last_load = 1'b1;
         n_redir++;
         phase = 2;
      end
      pc_load    <= last_load;
      dec_ready  <= ready_n;
      last_stb   = ibus_stb;
      last_adr   = ibus_adr;
      last_valid = dec_valid;
      last_ready = ready_n;
      n_steps++;
   endtask

   initial begin
      seed = 54;
      clk = 1'b0;
      rst_n = 1'b0;
      pc_load = 1'b0;
      pc_target = '0;
      dec_ready = 1'b0;
      {n_out, n_steps, n_redir, phase, bus_errs, out_errs, hold_errs} = '0;
      {pend, last_stb, last_load, last_valid, last_ready} = '0;
      exp_pc  = `RVDEC_RESET_PC;
      exp_bus = `RVDEC_RESET_PC;
      for (i = 0; i < 64; i++) begin
         gen_instr(prog[i]);
         u_imem.mem[i] = prog[i];
      end
      repeat (8) @(negedge clk);
      if (ibus_stb || dec_valid) begin
         bus_errs++;
         $display("ERR %0t: bus or output active during reset", $time);
      end
      rst_n <= 1'b1;
      while (n_out < N_OUT) begin
         @(negedge clk);
         check_and_drive();
      end
      $display("errors: bus %0d, output %0d, hold %0d over %0d outputs",
               bus_errs, out_errs, hold_errs, n_out);
      if (bus_errs + out_errs + hold_errs == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // decoder stopped producing outputs
   initial begin
      #(WDOG_NS);
      $display("watchdog expired with %0d of %0d outputs seen", n_out, N_OUT);
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: rvdec_top.f
+incdir+hw
hw/rvdec_pkg.sv
hw/rvdec_instr_if.sv
hw/rvdec_fetch.sv
hw/rvdec_ctrl_decode.sv
hw/rvdec_imm_decode.sv
hw/rvdec_top.sv
bench/rvdec_imem.sv
bench/rvdec_tb.sv

// File: Bender.yml
package:
  name: rvdec

export_include_dirs:
  - hw

sources:
  - hw/rvdec_pkg.sv
  - hw/rvdec_instr_if.sv
  - hw/rvdec_fetch.sv
  - hw/rvdec_ctrl_decode.sv
  - hw/rvdec_imm_decode.sv
  - hw/rvdec_top.sv
  - target: test
    files:
      - bench/rvdec_imem.sv
      - bench/rvdec_tb.sv
